// ==== logic/ic_settings.svh ====
////////////////////////////////////////
// Size macros for the instruction cache
////////////////////////////////////////
`ifndef IC_SETTINGS_SVH
`define IC_SETTINGS_SVH

// Physical byte address
`define IC_AW          16

// 16-byte lines, 16 sets, two ways
`define IC_P_LINE      4
`define IC_P_SETS      4
`define IC_WAYS        2

// One refill burst covers a whole line
`define IC_BURST_LEN   4
`define IC_P_BEATS     2           // log2 of the burst length
`define IC_INSN_W      32

`define IC_BOOT_SETS   (1 << `IC_P_SETS)   // Sets cleared after reset
`define IC_TAG_W       (`IC_AW - `IC_P_SETS - `IC_P_LINE)
`define IC_P_WORD      (`IC_P_LINE - `IC_P_BEATS)

`endif

// ==== logic/ic_cache_pkg.sv ====
////////////////////////////////////////
// Cache-side types: address fields,
// fetch request, controller states
////////////////////////////////////////
`include "ic_settings.svh"

package ic_cache_pkg;

   typedef logic [`IC_AW-1:0]       addr_t;
   typedef logic [`IC_TAG_W-1:0]    tag_t;
   typedef logic [`IC_P_SETS-1:0]   index_t;
   typedef logic [`IC_P_BEATS-1:0]  beat_t;    // Word within a line
   typedef logic [`IC_INSN_W-1:0]   insn_t;

   typedef struct packed {
      logic    valid;
      addr_t   addr;
   } fetch_req_t;

   typedef enum logic [2:0] {
      S_BOOT         = 3'd0,
      S_IDLE         = 3'd1,
      S_REPLACE      = 3'd2,
      S_REFILL       = 3'd3,
      S_INVALIDATE   = 3'd4
   } ctrl_state_t;

endpackage

// ==== logic/ic_bus_pkg.sv ====
////////////////////////////////////////
// Refill bus types: read address, beat
////////////////////////////////////////

package ic_bus_pkg;

   // Read address channel, one line per request
   typedef struct packed {
      logic                   valid;
      ic_cache_pkg::addr_t    addr;
   } ar_req_t;

   // Read data channel
   typedef struct packed {
      logic                   valid;
      ic_cache_pkg::insn_t    data;
      logic                   last;   // Fourth beat of the burst
   } r_beat_t;

endpackage

// ==== logic/ic_ctrl_fsm.sv ====
////////////////////////////////////////
// Cache controller state machine
////////////////////////////////////////
`timescale 1ns/100ps

module ic_ctrl_fsm
(
   input  logic                        clk,
   input  logic                        rst_n_i,
   input  logic                        lookup_valid_i,
   input  logic                        hit_i,
   input  logic                        inv_i,
   input  logic                        ar_ready_i,
   input  logic                        r_last_hs_i,
   input  logic                        count_done_i,
   output ic_cache_pkg::ctrl_state_t   state_o,
   output logic                        stall_o,
   output logic                        ar_valid_o,
   output logic                        r_ready_o
);

   ic_cache_pkg::ctrl_state_t state_q;
   ic_cache_pkg::ctrl_state_t state_nxt;
   logic                      ar_valid_q;
   logic                      miss;

   assign miss = lookup_valid_i & ~hit_i;

   // A pending miss keeps the lookup stage frozen on the missing address.
   // An invalidate offered together with a fetch runs before that fetch's lookup
   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         ic_cache_pkg::S_BOOT:
            if (count_done_i)
               state_nxt = ic_cache_pkg::S_IDLE;
         ic_cache_pkg::S_IDLE:
            if (inv_i & ~miss)
               state_nxt = ic_cache_pkg::S_INVALIDATE;
            else if (miss)
               state_nxt = ic_cache_pkg::S_REPLACE;
         ic_cache_pkg::S_REPLACE:
            state_nxt = ic_cache_pkg::S_REFILL;
         ic_cache_pkg::S_REFILL:
            if (r_last_hs_i)
               state_nxt = ic_cache_pkg::S_IDLE;
         ic_cache_pkg::S_INVALIDATE:
            state_nxt = ic_cache_pkg::S_IDLE;
         default:
            state_nxt = ic_cache_pkg::S_BOOT;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (~rst_n_i)
      begin
         state_q    <= ic_cache_pkg::S_BOOT;
         ar_valid_q <= 1'b0;
      end
      else
      begin
         state_q <= state_nxt;
         if (state_q == ic_cache_pkg::S_REPLACE)
            ar_valid_q <= 1'b1;     // Burst request goes out with refill
         else if (ar_ready_i)
            ar_valid_q <= 1'b0;
      end
   end

   assign state_o    = state_q;
   assign stall_o    = (state_q != ic_cache_pkg::S_IDLE) | miss;
   assign ar_valid_o = ar_valid_q;
   assign r_ready_o  = (state_q == ic_cache_pkg::S_REFILL);

   // Data beats only arrive once the burst address was accepted
   a_r_after_ar: assert property (@(posedge clk) disable iff (~rst_n_i)
      r_last_hs_i |-> ~ar_valid_o);

endmodule

// ==== logic/ic_refill_counter.sv ====
////////////////////////////////////////
// Boot set and refill beat counter
////////////////////////////////////////
`timescale 1ns/100ps

`include "ic_settings.svh"

module ic_refill_counter
(
   input  logic                        clk,
   input  logic                        rst_n_i,
   input  ic_cache_pkg::ctrl_state_t   state_i,
   input  logic                        beat_hs_i,
   output ic_cache_pkg::index_t        count_o,
   output logic                        count_done_o
);

   ic_cache_pkg::index_t count_q;

   always_ff @(posedge clk)
   begin
      if (~rst_n_i)
         count_q <= '0;
      else
      begin
         case (state_i)
            ic_cache_pkg::S_BOOT:
               count_q <= count_q + 1'b1;     // One set per cycle
            ic_cache_pkg::S_REFILL:
               if (beat_hs_i)
                  count_q <= count_q + 1'b1;  // Next word of the line
            default:
               count_q <= '0;
         endcase
      end
   end

   assign count_o = count_q;

   // Last set of the boot sweep
   assign count_done_o = (state_i == ic_cache_pkg::S_BOOT) &
                         (count_q == ic_cache_pkg::index_t'(`IC_BOOT_SETS - 1));

endmodule

// ==== logic/ic_tag_array.sv ====
////////////////////////////////////////
// Tag, valid and victim storage, hit check
////////////////////////////////////////
`timescale 1ns/100ps

`include "ic_settings.svh"

module ic_tag_array
(
   input  logic                        clk,
   input  logic                        rst_n_i,
   input  ic_cache_pkg::ctrl_state_t   state_i,
   input  ic_cache_pkg::index_t        rd_index_i,
   input  ic_cache_pkg::tag_t          lookup_tag_i,
   input  ic_cache_pkg::index_t        wr_index_i,
   input  ic_cache_pkg::tag_t          wr_tag_i,
   output logic                        hit_o,
   output logic                        hit_way_o,
   output logic                        victim_way_o
);

   ic_cache_pkg::tag_t  tag_q    [`IC_WAYS][`IC_BOOT_SETS];
   logic                valid_q  [`IC_WAYS][`IC_BOOT_SETS];
   logic                victim_q [`IC_BOOT_SETS];      // Round-robin pointer per set
   logic [`IC_WAYS-1:0] way_hit;
   logic                wr_way;

   assign wr_way = victim_q[wr_index_i];

   always_ff @(posedge clk)
   begin
      case (state_i)
         ic_cache_pkg::S_BOOT,
         ic_cache_pkg::S_INVALIDATE:
         begin
            for (int w = 0; w < `IC_WAYS; w++)
               valid_q[w][wr_index_i] <= 1'b0;
            if (state_i == ic_cache_pkg::S_BOOT)
               victim_q[wr_index_i] <= 1'b0;
         end
         ic_cache_pkg::S_REPLACE:
         begin
            tag_q[wr_way][wr_index_i]   <= wr_tag_i;
            valid_q[wr_way][wr_index_i] <= 1'b1;
            victim_q[wr_index_i]        <= ~wr_way;
         end
         default:
            ;
      endcase
   end

   // Lookup stage compare, read straight from the flops
   always_comb
   begin
      for (int w = 0; w < `IC_WAYS; w++)
         way_hit[w] = valid_q[w][rd_index_i] & (tag_q[w][rd_index_i] == lookup_tag_i);
   end

   assign hit_o        = |way_hit;
   assign hit_way_o    = way_hit[1];
   assign victim_way_o = victim_q[rd_index_i];

   // Replacement only fills on a miss, so a line never sits in both ways
   a_one_way_hits: assert property (@(posedge clk) disable iff (~rst_n_i)
      state_i != ic_cache_pkg::S_BOOT |-> $onehot0(way_hit));

endmodule

// ==== logic/ic_data_array.sv ====
////////////////////////////////////////
// Instruction storage and output select
////////////////////////////////////////
`timescale 1ns/100ps

`include "ic_settings.svh"

module ic_data_array
(
   input  logic                        clk,
   input  ic_cache_pkg::ctrl_state_t   state_i,
   input  ic_cache_pkg::addr_t         rd_addr_i,
   input  logic                        hit_way_i,
   input  logic                        fill_way_i,
   input  ic_cache_pkg::index_t        fill_index_i,
   input  ic_cache_pkg::beat_t         fill_beat_i,
   input  ic_bus_pkg::r_beat_t         beat_i,
   input  ic_cache_pkg::beat_t         want_beat_i,
   output ic_cache_pkg::insn_t         insn_o
);

   ic_cache_pkg::insn_t mem_q [`IC_WAYS][`IC_BOOT_SETS * `IC_BURST_LEN];
   ic_cache_pkg::insn_t rd_q  [`IC_WAYS];
   ic_cache_pkg::insn_t fill_word_q;       // Requested word seen on the bus
   logic                from_fill_q;
   logic                fill_we;
   logic [`IC_P_SETS+`IC_P_BEATS-1:0] rd_word;
   logic [`IC_P_SETS+`IC_P_BEATS-1:0] wr_word;

   // Ready is high through the whole refill
   assign fill_we = (state_i == ic_cache_pkg::S_REFILL) & beat_i.valid;
   assign rd_word = rd_addr_i[`IC_P_WORD +: `IC_P_SETS + `IC_P_BEATS];
   assign wr_word = {fill_index_i, fill_beat_i};

   always_ff @(posedge clk)
   begin
      if (fill_we)
         mem_q[fill_way_i][wr_word] <= beat_i.data;
      for (int w = 0; w < `IC_WAYS; w++)
         rd_q[w] <= mem_q[w][rd_word];
      if (fill_we & (fill_beat_i == want_beat_i))
         fill_word_q <= beat_i.data;
      from_fill_q <= (state_i == ic_cache_pkg::S_REFILL);
   end

   // First cycle after refill answers from the captured beat
   assign insn_o = from_fill_q ? fill_word_q : rd_q[hit_way_i];

endmodule

// ==== logic/ic_top.sv ====
////////////////////////////////////////
// Instruction cache top level
////////////////////////////////////////
`timescale 1ns/100ps

`include "ic_settings.svh"

module ic_top
(
   input  logic                        clk,
   input  logic                        rst_n_i,
   input  ic_cache_pkg::fetch_req_t    req_i,
   input  logic                        inv_i,
   input  ic_cache_pkg::addr_t         inv_addr_i,
   output logic                        stall_o,
   output logic                        rsp_valid_o,
   output ic_cache_pkg::insn_t         rsp_insn_o,
   output ic_bus_pkg::ar_req_t         ar_o,
   input  logic                        ar_ready_i,
   input  ic_bus_pkg::r_beat_t         r_i,
   output logic                        r_ready_o
);

   ic_cache_pkg::fetch_req_t  s1_q;
   ic_cache_pkg::addr_t       inv_addr_q;
   logic                      fill_way_q;
   ic_cache_pkg::ctrl_state_t state;
   ic_cache_pkg::index_t      count;
   ic_cache_pkg::index_t      s1_index;
   ic_cache_pkg::index_t      wr_index;
   ic_cache_pkg::tag_t        s1_tag;
   ic_cache_pkg::addr_t       rd_addr;
   logic                      count_done;
   logic                      hit;
   logic                      hit_way;
   logic                      victim_way;
   logic                      ar_valid;
   logic                      beat_hs;
   logic                      last_hs;

   always_ff @(posedge clk)
   begin
      if (~stall_o)
         s1_q.addr <= req_i.addr;
      if (~stall_o & inv_i)
         inv_addr_q <= inv_addr_i;
      if (state == ic_cache_pkg::S_REPLACE)
         fill_way_q <= victim_way;        // Way picked before the pointer moves
      if (~rst_n_i)
         s1_q.valid <= 1'b0;
      else if (~stall_o)
         s1_q.valid <= req_i.valid;
   end

   assign s1_index = s1_q.addr[`IC_P_LINE +: `IC_P_SETS];
   assign s1_tag   = s1_q.addr[`IC_AW-1 -: `IC_TAG_W];
   assign rd_addr  = stall_o ? s1_q.addr : req_i.addr;   // Re-read while frozen
   assign beat_hs  = r_i.valid & r_ready_o;
   assign last_hs  = beat_hs & r_i.last;

   always_comb
   begin
      case (state)
         ic_cache_pkg::S_BOOT:        wr_index = count;
         ic_cache_pkg::S_INVALIDATE:  wr_index = inv_addr_q[`IC_P_LINE +: `IC_P_SETS];
         default:                     wr_index = s1_index;
      endcase
   end

   ic_ctrl_fsm i_ctrl_fsm (
      .clk(clk), .rst_n_i(rst_n_i),
      .lookup_valid_i(s1_q.valid), .hit_i(hit), .inv_i(inv_i),
      .ar_ready_i(ar_ready_i), .r_last_hs_i(last_hs), .count_done_i(count_done),
      .state_o(state), .stall_o(stall_o), .ar_valid_o(ar_valid), .r_ready_o(r_ready_o)
   );

   ic_refill_counter i_refill_counter (
      .clk(clk), .rst_n_i(rst_n_i), .state_i(state), .beat_hs_i(beat_hs),
      .count_o(count), .count_done_o(count_done)
   );

   ic_tag_array i_tag_array (
      .clk(clk), .rst_n_i(rst_n_i), .state_i(state),
      .rd_index_i(s1_index), .lookup_tag_i(s1_tag),
      .wr_index_i(wr_index), .wr_tag_i(s1_tag),
      .hit_o(hit), .hit_way_o(hit_way), .victim_way_o(victim_way)
   );

   ic_data_array i_data_array (
      .clk(clk), .state_i(state), .rd_addr_i(rd_addr), .hit_way_i(hit_way),
      .fill_way_i(fill_way_q), .fill_index_i(s1_index),
      .fill_beat_i(count[`IC_P_BEATS-1:0]), .beat_i(r_i),
      .want_beat_i(s1_q.addr[`IC_P_WORD +: `IC_P_BEATS]), .insn_o(rsp_insn_o)
   );

   // Line address of the missing fetch, held while s1 is frozen
   assign ar_o.valid = ar_valid;
   assign ar_o.addr  = {s1_q.addr[`IC_AW-1:`IC_P_LINE], {`IC_P_LINE{1'b0}}};

   assign rsp_valid_o = (state == ic_cache_pkg::S_IDLE) & s1_q.valid & hit;

   // Burst request and its line address hold until the slave takes them
   a_ar_stable: assert property (@(posedge clk) disable iff (~rst_n_i)
      ar_o.valid & ~ar_ready_i |=> ar_o.valid & $stable(ar_o.addr));

endmodule

// ==== tb/tb_ic_mem_model.sv ====
////////////////////////////////////////
// Read bus slave for cache refills
////////////////////////////////////////
`timescale 1ns/100ps

`include "ic_settings.svh"

module tb_ic_mem_model
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  ic_bus_pkg::ar_req_t   ar_i,
   output logic                  ar_ready_o,
   output ic_bus_pkg::r_beat_t   r_o,
   input  logic                  r_ready_i,
   output int                    err_o
);

   integer              seed;
   int                  delay;
   int                  wait_cnt;
   int                  beat;
   ic_cache_pkg::addr_t word_addr;

   initial
   begin
      seed       = 32'h94aa_a366;
      ar_ready_o = 1'b0;
      r_o        = '0;
      err_o      = 0;
      forever
      begin
         @(posedge clk);
         #1;
         if (rst_n_i && ar_i.valid)
         begin
            delay = $unsigned($random(seed)) % 4;    // Address channel back-pressure
            repeat (delay)
            begin
               @(posedge clk);
               #1;
            end
            word_addr  = ar_i.addr;
            ar_ready_o = 1'b1;
            @(posedge clk);
            #1;
            ar_ready_o = 1'b0;
            for (beat = 0; beat < `IC_BURST_LEN; beat++)
            begin
               delay = $unsigned($random(seed)) % 4;
               repeat (delay)
               begin
                  @(posedge clk);
                  #1;
               end
               r_o.valid = 1'b1;
               r_o.data  = {word_addr, ~word_addr};  // Word address, then its inverse
               r_o.last  = (beat == `IC_BURST_LEN - 1);
               wait_cnt  = 0;
               @(negedge clk);
               while (!r_ready_i && wait_cnt < 50)
               begin
                  @(negedge clk);
                  wait_cnt++;
               end
               if (!r_ready_i)
               begin
                  $display("%0t: memory model saw no r_ready for a refill beat", $time);
                  err_o++;
               end
               @(posedge clk);
               #1;
               r_o       = '0;
               word_addr = word_addr + 16'd4;
            end
         end
      end
   end

endmodule

// ==== tb/tb_ic_top.sv ====
////////////////////////////////////////
// Testbench for the instruction cache
////////////////////////////////////////
`timescale 1ns/100ps

`include "ic_settings.svh"

module tb_ic_top;

   localparam int K_FETCH  = 0;
   localparam int K_INV    = 1;
   localparam int K_STREAM = 2;     // Four back-to-back words of one line
   localparam int E_HIT    = 0;
   localparam int E_MISS   = 1;
   localparam int E_MODEL  = 2;     // Outcome taken from the reference model
   localparam int TIMEOUT  = 200;

   typedef struct packed {
      logic [1:0]          kind;
      ic_cache_pkg::addr_t addr;
      logic [1:0]          exp;
   } op_t;

   logic                      clk;
   logic                      rst_n_i;
   ic_cache_pkg::fetch_req_t  req;
   logic                      inv;
   ic_cache_pkg::addr_t       inv_addr;
   logic                      stall_o;
   logic                      rsp_valid_o;
   ic_cache_pkg::insn_t       rsp_insn_o;
   ic_bus_pkg::ar_req_t       ar_o;
   logic                      ar_ready_i;
   ic_bus_pkg::r_beat_t       r_i;
   logic                      r_ready_o;

   int                        val_errs;
   int                        other_errs;
   int                        mem_errs;
   int                        bursts;
   ic_cache_pkg::addr_t       last_ar_addr;
   integer                    seed;
   op_t                       ops[$];

   // Reference model of tags and round-robin bits
   ic_cache_pkg::tag_t        m_tag    [`IC_BOOT_SETS][`IC_WAYS];
   logic                      m_valid  [`IC_BOOT_SETS][`IC_WAYS];
   logic                      m_victim [`IC_BOOT_SETS];

   ic_top i_ic_top (
      .clk(clk), .rst_n_i(rst_n_i), .req_i(req), .inv_i(inv), .inv_addr_i(inv_addr),
      .stall_o(stall_o), .rsp_valid_o(rsp_valid_o), .rsp_insn_o(rsp_insn_o),
      .ar_o(ar_o), .ar_ready_i(ar_ready_i), .r_i(r_i), .r_ready_o(r_ready_o)
   );

   tb_ic_mem_model i_mem_model (
      .clk(clk), .rst_n_i(rst_n_i), .ar_i(ar_o), .ar_ready_o(ar_ready_i),
      .r_o(r_i), .r_ready_i(r_ready_o), .err_o(mem_errs)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Burst address handshakes, sampled mid-cycle
   always @(negedge clk)
   begin
      if (ar_o.valid && ar_ready_i)
      begin
         bursts++;
         last_ar_addr = ar_o.addr;
      end
   end

   function automatic ic_cache_pkg::insn_t expected_word(ic_cache_pkg::addr_t a);
      ic_cache_pkg::addr_t w;
      w = {a[`IC_AW-1:2], 2'b00};
      return {w, ~w};
   endfunction

   function automatic op_t make_op(int kind, ic_cache_pkg::addr_t a, int exp);
      op_t op;
      op.kind = kind[1:0];
      op.addr = a;
      op.exp  = exp[1:0];
      return op;
   endfunction

   // Returns 1 on a miss and fills the victim way like the cache does
   function automatic logic model_lookup(ic_cache_pkg::addr_t a);
      ic_cache_pkg::index_t idx;
      ic_cache_pkg::tag_t   tg;
      logic                 miss;
      logic                 way;
      idx  = a[`IC_P_LINE +: `IC_P_SETS];
      tg   = a[`IC_AW-1 -: `IC_TAG_W];
      miss = !((m_valid[idx][0] && m_tag[idx][0] == tg) ||
               (m_valid[idx][1] && m_tag[idx][1] == tg));
      if (miss)
      begin
         way                = m_victim[idx];
         m_tag[idx][way]    = tg;
         m_valid[idx][way]  = 1'b1;
         m_victim[idx]      = ~way;
      end
      return miss;
   endfunction

   task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
      if (got !== exp)
      begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         val_errs++;
      end
   endtask

   task automatic report_failure(string msg);
      $display("%0t: %s", $time, msg);
      other_errs++;
   endtask

   // Ends on the negedge before the accepting rising edge
   task automatic wait_accept(output logic ok);
      int t;
      ok = 1'b0;
      t  = 0;
      while (!ok && t < TIMEOUT)
      begin
         @(negedge clk);
         ok = !stall_o;
         t++;
      end
   endtask

   task automatic do_fetch(ic_cache_pkg::addr_t a, logic exp_miss);
      int   b0;
      int   lat;
      logic ok;
      logic got;
      b0        = bursts;
      req.valid = 1'b1;
      req.addr  = a;
      wait_accept(ok);
      if (!ok)
         report_failure("fetch was never accepted, stall_o stayed high");
      @(posedge clk);
      #1;
      req.valid = 1'b0;
      lat = 0;
      got = 1'b0;
      while (!got && lat < TIMEOUT)
      begin
         @(negedge clk);
         lat++;
         got = rsp_valid_o;
      end
      if (!got)
         report_failure("no fetch response before timeout");
      else
      begin
         check_value("rsp_insn_o", rsp_insn_o, expected_word(a));
         if (!exp_miss)
            check_value("hit latency", lat, 1);
         check_value("burst count", bursts - b0, {31'd0, exp_miss});
         if (exp_miss)
            check_value("ar_o.addr", last_ar_addr, {a[`IC_AW-1:`IC_P_LINE], 4'h0});
      end
      @(posedge clk);
      #1;
   endtask

   task automatic do_stream(ic_cache_pkg::addr_t base);
      int b0;
      b0 = bursts;
      for (int k = 0; k < `IC_BURST_LEN; k++)
      begin
         req.valid = 1'b1;
         req.addr  = base + 16'(4 * k);
         @(negedge clk);
         if (stall_o)
            report_failure("back-to-back fetch in a cached line was stalled");
         if (k > 0)
         begin
            if (!rsp_valid_o)
               report_failure("back-to-back fetch gave no response in its cycle");
            else
               check_value("rsp_insn_o", rsp_insn_o, expected_word(base + 16'(4 * (k - 1))));
         end
         @(posedge clk);
         #1;
      end
      req.valid = 1'b0;
      @(negedge clk);
      if (!rsp_valid_o)
         report_failure("last back-to-back fetch gave no response");
      else
         check_value("rsp_insn_o", rsp_insn_o, expected_word(base + 16'd12));
      check_value("burst count", bursts - b0, 0);
      @(posedge clk);
      #1;
   endtask

   task automatic do_inv(ic_cache_pkg::addr_t a);
      logic ok;
      inv      = 1'b1;
      inv_addr = a;
      wait_accept(ok);
      if (!ok)
         report_failure("invalidate was never accepted");
      @(posedge clk);
      #1;
      inv = 1'b0;
   endtask

   initial
   begin
      logic miss;
      int   t;
      int   sel;
      int   word;
      rst_n_i    = 1'b0;
      req        = '0;
      inv        = 1'b0;
      inv_addr   = '0;
      val_errs   = 0;
      other_errs = 0;
      bursts     = 0;
      seed       = 32'h94aa_a366;
      for (int s = 0; s < `IC_BOOT_SETS; s++)
      begin
         m_valid[s][0] = 1'b0;
         m_valid[s][1] = 1'b0;
         m_victim[s]   = 1'b0;
      end

      // Set 3: lines A, B, C share the index
      ops.push_back(make_op(K_FETCH,  16'h1238, E_MISS));
      ops.push_back(make_op(K_FETCH,  16'h1234, E_HIT));
      ops.push_back(make_op(K_STREAM, 16'h1230, E_HIT));
      ops.push_back(make_op(K_FETCH,  16'h453C, E_MISS));
      ops.push_back(make_op(K_FETCH,  16'h1230, E_HIT));
      ops.push_back(make_op(K_FETCH,  16'h4530, E_HIT));
      ops.push_back(make_op(K_FETCH,  16'h7830, E_MISS));    // Evicts A from way 0
      ops.push_back(make_op(K_FETCH,  16'h4534, E_HIT));
      ops.push_back(make_op(K_FETCH,  16'h1230, E_MISS));
      ops.push_back(make_op(K_FETCH,  16'h7830, E_HIT));
      ops.push_back(make_op(K_INV,    16'h0030, E_MODEL));
      ops.push_back(make_op(K_FETCH,  16'h7834, E_MISS));
      ops.push_back(make_op(K_FETCH,  16'h1234, E_MISS));
      for (int i = 0; i < 40; i++)
      begin
         sel  = $unsigned($random(seed)) % 8;
         word = $unsigned($random(seed)) % 4;
         ops.push_back(make_op(K_FETCH, {8'hA0 + 8'(sel / 4), 4'(8 + sel % 4),
                                         2'(word), 2'b00}, E_MODEL));
      end

      repeat (3) @(posedge clk);
      #1;
      rst_n_i = 1'b1;

      // Boot sweep must finish without bus traffic
      t = 0;
      @(negedge clk);
      while (stall_o && t < 40)
      begin
         if (ar_o.valid)
            report_failure("ar_o.valid raised during boot");
         @(negedge clk);
         t++;
      end
      if (stall_o)
         report_failure("stall_o still high 40 cycles after reset");
      @(posedge clk);
      #1;

      foreach (ops[i])
      begin
         case (int'(ops[i].kind))
            K_FETCH:
            begin
               miss = model_lookup(ops[i].addr);
               if (ops[i].exp != E_MODEL)
                  miss = ops[i].exp[0];      // Hand-derived outcome of the row
               do_fetch(ops[i].addr, miss);
            end
            K_STREAM:
            begin
               do_stream(ops[i].addr);
            end
            default:
            begin
               m_valid[ops[i].addr[`IC_P_LINE +: `IC_P_SETS]][0] = 1'b0;
               m_valid[ops[i].addr[`IC_P_LINE +: `IC_P_SETS]][1] = 1'b0;
               do_inv(ops[i].addr);
            end
         endcase
      end

      repeat (4) @(posedge clk);
      $display("errors: %0d value mismatches, %0d other failures", val_errs,
               other_errs + mem_errs);
      if (val_errs + other_errs + mem_errs == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// ==== ic_cache.f ====
+incdir+logic
logic/ic_cache_pkg.sv
logic/ic_bus_pkg.sv
logic/ic_ctrl_fsm.sv
logic/ic_refill_counter.sv
logic/ic_tag_array.sv
logic/ic_data_array.sv
logic/ic_top.sv
tb/tb_ic_mem_model.sv
tb/tb_ic_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module tb_ic_top -f ic_cache.f --Mdir obj_dir -o sim_ic > build.log 2>&1
if [ $? -ne 0 ]; then
   cat build.log
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/sim_ic > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "test failed" sim.log; then
   exit 1
fi
exit 0
